// ==== Bender.yml ====
package:
  name: synthesizer

sources:
  - common/synthPkg.sv
  - common/dmaCtrlIf.sv
  - logic/sampleFifo.sv
  - logic/i2sTransmitter.sv
  - synthesizer/synthesizerCsr.sv
  - synthesizer/sampleRam.sv
  - synthesizer/sampleDma.sv
  - synthesizer/synthesizerTop.sv
  - target: simulation
    files:
      - verification/synthesizerTb.sv

// ==== build.f ====
common/synthPkg.sv
common/dmaCtrlIf.sv
logic/sampleFifo.sv
logic/i2sTransmitter.sv
synthesizer/synthesizerCsr.sv
synthesizer/sampleRam.sv
synthesizer/sampleDma.sv
synthesizer/synthesizerTop.sv
verification/synthesizerTb.sv

// ==== common/dmaCtrlIf.sv ====
//--------------------------------------------------
// DMA control link
// Window and enable from the CSR, done from the DMA
//--------------------------------------------------
`default_nettype none

interface dmaCtrlIf #(
	parameter int pDmaAdrsWidth = 8
) ();

	// First sample address of the window
	logic [pDmaAdrsWidth-1:0] adrsStart;
	// Last sample address, inclusive
	logic [pDmaAdrsWidth-1:0] adrsEnd;
	// Transfer enable level
	logic                     enable;
	// One-cycle pulse after the last sample is pushed
	logic                     done;

	modport csr (
		output adrsStart,
		output adrsEnd,
		output enable,
		input  done
	);

	modport dma (
		input  adrsStart,
		input  adrsEnd,
		input  enable,
		output done
	);

endinterface

`default_nettype wire

// ==== common/synthPkg.sv ====
//--------------------------------------------------
// Synthesizer shared definitions
// Bus address map, CSR offsets and DMA states
//--------------------------------------------------
`default_nettype none

package synthPkg;

	//--------------------------------------------------
	// Bus layout
	//--------------------------------------------------
	// Data and address width
	localparam int cBusWidth    = 32;
	// Address bit set on a write
	localparam int cWriteBit    = 30;
	// Offset field inside a block, bits 15:0
	localparam int cOffsetWidth = 16;
	// Block select field, bits 23:16
	localparam int cBlockWidth  = 8;

	// CSR register offsets
	typedef enum logic [cOffsetWidth-1:0] {
		offI2sRst    = 16'h0000,
		offDmaStart  = 16'h0004,
		offDmaEnd    = 16'h0008,
		offDmaEnable = 16'h000C,
		offDmaCycle  = 16'h0010
	} csrOffset;

	// DMA reader states
	typedef enum logic [1:0] {
		dmaIdle,
		dmaRead,
		dmaWait
	} dmaState;

endpackage

`default_nettype wire

// ==== logic/i2sTransmitter.sv ====
//--------------------------------------------------
// I2S transmitter
// Bit clock from iSCLK, left channel on low word
// select, MSB first with the one-bit delay
//--------------------------------------------------
`default_nettype none

module i2sTransmitter #(
	parameter int pSampleWidth = 16,
	parameter int pBclkDiv     = 2
)(
	input  logic                    iSCLK,
	input  logic                    iSRST,
	input  logic                    i2sRst,
	output logic                    fifoPop,
	input  logic [pSampleWidth-1:0] fifoRdData,
	input  logic                    fifoEmpty,
	output logic                    bclk,
	output logic                    lrclk,
	output logic                    sdata
);

	localparam int cDivWidth = $clog2(pBclkDiv + 1);
	localparam int cBitWidth = $clog2(pSampleWidth);

	logic [cDivWidth-1:0]    divCnt;
	logic [cBitWidth-1:0]    bitCnt;
	logic [pSampleWidth-1:0] shiftReg;
	// Half bit clock elapsed
	logic                    tick;
	// Bit clock about to fall
	logic                    fall;
	// Last bit of the word, word select flips
	logic                    boundary;

	assign tick     = !i2sRst && (divCnt == cDivWidth'(pBclkDiv - 1));
	assign fall     = tick && bclk;
	assign boundary = fall && (bitCnt == cBitWidth'(pSampleWidth - 1));
	// One pop per channel word
	assign fifoPop  = boundary && !fifoEmpty;

	//--------------------------------------------------
	// Clock divider and serializer
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || i2sRst)
		begin
			divCnt   <= '0;
			bclk     <= 1'b0;
			lrclk    <= 1'b0;
			sdata    <= 1'b0;
			bitCnt   <= '0;
			shiftReg <= '0;
		end
		else
		begin
			if (tick)
			begin
				divCnt <= '0;
				bclk   <= ~bclk;
			end
			else
				divCnt <= divCnt + 1'b1;

			// Data moves on the falling edge
			if (fall)
			begin
				// Previous word's LSB goes out with the WS change
				sdata <= shiftReg[pSampleWidth-1];
				if (boundary)
				begin
					lrclk    <= ~lrclk;
					bitCnt   <= '0;
					// Zeros when starved
					shiftReg <= fifoEmpty ? '0 : fifoRdData;
				end
				else
				begin
					bitCnt   <= bitCnt + 1'b1;
					shiftReg <= {shiftReg[pSampleWidth-2:0], 1'b0};
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sampleFifo.sv ====
//--------------------------------------------------
// Sample FIFO
// Circular buffer, first-word-fall-through output
//--------------------------------------------------
`default_nettype none

module sampleFifo #(
	parameter int pSampleWidth  = 16,
	parameter int pFifoDepthLog = 2
)(
	input  logic                    iSCLK,
	input  logic                    iSRST,
	input  logic                    write,
	input  logic [pSampleWidth-1:0] wrData,
	output logic                    full,
	input  logic                    pop,
	output logic [pSampleWidth-1:0] rdData,
	output logic                    empty
);

	localparam int cDepth = 2**pFifoDepthLog;

	logic [pSampleWidth-1:0] mem [cDepth];
	// Pointers carry one wrap bit above the index
	logic [pFifoDepthLog:0]  wrPtr;
	logic [pFifoDepthLog:0]  rdPtr;
	logic                    doWrite;
	logic                    doPop;

	// Same index, different lap
	assign full  = (wrPtr[pFifoDepthLog] != rdPtr[pFifoDepthLog]) &&
		(wrPtr[pFifoDepthLog-1:0] == rdPtr[pFifoDepthLog-1:0]);
	assign empty = wrPtr == rdPtr;

	// Ignore push on full, pop on empty
	assign doWrite = write && !full;
	assign doPop   = pop && !empty;

	// Head word always on the output
	assign rdData = mem[rdPtr[pFifoDepthLog-1:0]];

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge iSCLK)
	begin
		if (doWrite)
			mem[wrPtr[pFifoDepthLog-1:0]] <= wrData;
	end

endmodule

`default_nettype wire

// ==== synthesizer/sampleDma.sv ====
//--------------------------------------------------
// Sample DMA reader
// Walks the memory window and feeds the FIFO,
// one read in flight, re-reads on a full FIFO
//--------------------------------------------------
`default_nettype none

module sampleDma
	import synthPkg::*;
#(
	parameter int pDmaAdrsWidth = 8,
	parameter int pSampleWidth  = 16
)(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	dmaCtrlIf.dma                    dmaCtrl,
	output logic [pDmaAdrsWidth-1:0] ramRdAdrs,
	input  logic [pSampleWidth-1:0]  ramRdData,
	output logic                     fifoWrite,
	output logic [pSampleWidth-1:0]  fifoWrData,
	input  logic                     fifoFull
);

	dmaState                  state;
	logic [pDmaAdrsWidth-1:0] adrs;
	// RAM data valid this cycle
	logic                     pending;
	// Last sample pushed, waiting for done
	logic                     finish;
	logic                     doneReg;
	logic                     isLast;

	assign ramRdAdrs    = adrs;
	assign dmaCtrl.done = doneReg;
	assign isLast       = adrs == dmaCtrl.adrsEnd;

	//--------------------------------------------------
	// Control FSM
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state     <= dmaIdle;
			pending   <= 1'b0;
			finish    <= 1'b0;
			fifoWrite <= 1'b0;
			doneReg   <= 1'b0;
		end
		else
		begin
			fifoWrite <= 1'b0;
			// Pulse in the cycle after the last push
			doneReg   <= fifoWrite & finish;
			case (state)
				dmaIdle:
					if (dmaCtrl.enable)
						state <= dmaRead;
				dmaRead:
					if (doneReg)
					begin
						state  <= dmaWait;
						finish <= 1'b0;
					end
					else if (pending)
					begin
						pending <= 1'b0;
						// Full drops the data, address is kept for a re-read
						if (!fifoFull)
						begin
							fifoWrite <= 1'b1;
							finish    <= isLast;
						end
					end
					else if (!finish)
					begin
						// Issue next read, or stop when disabled
						if (dmaCtrl.enable)
							pending <= 1'b1;
						else
							state <= dmaIdle;
					end
				// CSR enable has been reloaded by now
				dmaWait:
					state <= dmaCtrl.enable ? dmaRead : dmaIdle;
				default:
					state <= dmaIdle;
			endcase
		end
	end

	//--------------------------------------------------
	// Address and data path
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if ((state == dmaIdle) || (state == dmaWait))
			adrs <= dmaCtrl.adrsStart;
		else if (pending && !fifoFull && !isLast)
			adrs <= adrs + 1'b1;
		// Capture returned sample
		if (pending)
			fifoWrData <= ramRdData;
	end

endmodule

`default_nettype wire

// ==== synthesizer/sampleRam.sv ====
//--------------------------------------------------
// Sample memory
// Written over the bus, read by the DMA reader
//--------------------------------------------------
`default_nettype none

module sampleRam
	import synthPkg::*;
#(
	parameter int                     pDmaAdrsWidth = 8,
	parameter int                     pSampleWidth  = 16,
	parameter logic [cBlockWidth-1:0] pRamBlock     = 8'h05
)(
	input  logic                     iSCLK,
	input  logic [cBusWidth-1:0]     iSUsiWd,
	input  logic [cBusWidth-1:0]     iSUsiAdrs,
	input  logic [pDmaAdrsWidth-1:0] rdAdrs,
	output logic [pSampleWidth-1:0]  rdData
);

	logic [pSampleWidth-1:0]  mem [2**pDmaAdrsWidth];
	logic                     wrHit;
	logic [pDmaAdrsWidth-1:0] wrAdrs;

	// Write to this block's window
	assign wrHit  = iSUsiAdrs[cWriteBit] &&
		(iSUsiAdrs[cOffsetWidth +: cBlockWidth] == pRamBlock);
	// Byte offset to word address
	assign wrAdrs = iSUsiAdrs[2 +: pDmaAdrsWidth];

	always_ff @(posedge iSCLK)
	begin
		// Low sample bits only
		if (wrHit)
			mem[wrAdrs] <= iSUsiWd[pSampleWidth-1:0];
		// Registered DMA read
		rdData <= mem[rdAdrs];
	end

endmodule

`default_nettype wire

// ==== synthesizer/synthesizerCsr.sv ====
//--------------------------------------------------
// Synthesizer control and status registers
// Bus-decoded writes, registered readback,
// DMA enable reload on done for cycle mode
//--------------------------------------------------
`default_nettype none

module synthesizerCsr
	import synthPkg::*;
#(
	parameter int                     pDmaAdrsWidth = 8,
	parameter logic [cBlockWidth-1:0] pCsrBlock     = 8'h04
)(
	input  logic                 iSCLK,
	input  logic                 iSRST,
	input  logic [cBusWidth-1:0] iSUsiWd,
	input  logic [cBusWidth-1:0] iSUsiAdrs,
	output logic [cBusWidth-1:0] oSUsiRd,
	output logic                 oI2sRst,
	dmaCtrlIf.csr                dmaCtrl
);

	//--------------------------------------------------
	// Address decode
	//--------------------------------------------------
	logic                     blockHit;
	logic                     wrHit;
	csrOffset                 offset;
	logic                     wrI2sRst;
	logic                     wrStart;
	logic                     wrEnd;
	logic                     wrEnable;
	logic                     wrCycle;
	logic                     cycleReg;
	logic [pDmaAdrsWidth-1:0] startReg;
	logic [pDmaAdrsWidth-1:0] endReg;
	logic                     enableReg;
	logic [cBusWidth-1:0]     rdNext;

	// Block field sits just above the offset
	assign blockHit = iSUsiAdrs[cOffsetWidth +: cBlockWidth] == pCsrBlock;
	assign wrHit    = iSUsiAdrs[cWriteBit] & blockHit;
	assign offset   = csrOffset'(iSUsiAdrs[cOffsetWidth-1:0]);

	// Per-register write strobes
	assign wrI2sRst = wrHit && (offset == offI2sRst);
	assign wrStart  = wrHit && (offset == offDmaStart);
	assign wrEnd    = wrHit && (offset == offDmaEnd);
	assign wrEnable = wrHit && (offset == offDmaEnable);
	assign wrCycle  = wrHit && (offset == offDmaCycle);

	//--------------------------------------------------
	// Register file
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oI2sRst   <= 1'b0;
			startReg  <= '0;
			endReg    <= '1;
			enableReg <= 1'b0;
			cycleReg  <= 1'b0;
		end
		else
		begin
			if (wrI2sRst)
				oI2sRst <= iSUsiWd[0];
			if (wrStart)
				startReg <= iSUsiWd[pDmaAdrsWidth-1:0];
			if (wrEnd)
				endReg <= iSUsiWd[pDmaAdrsWidth-1:0];
			// Done wins, reload from cycle mode
			if (dmaCtrl.done)
				enableReg <= cycleReg;
			else if (wrEnable)
				enableReg <= iSUsiWd[0];
			if (wrCycle)
				cycleReg <= iSUsiWd[0];
		end
	end

	assign dmaCtrl.adrsStart = startReg;
	assign dmaCtrl.adrsEnd   = endReg;
	assign dmaCtrl.enable    = enableReg;

	//--------------------------------------------------
	// Readback
	//--------------------------------------------------
	// Zero padded, zero outside the map
	always_comb
	begin
		rdNext = '0;
		if (blockHit)
		begin
			case (offset)
				offI2sRst:    rdNext[0] = oI2sRst;
				offDmaStart:  rdNext[pDmaAdrsWidth-1:0] = startReg;
				offDmaEnd:    rdNext[pDmaAdrsWidth-1:0] = endReg;
				offDmaEnable: rdNext[0] = enableReg;
				offDmaCycle:  rdNext[0] = cycleReg;
				default:      rdNext = '0;
			endcase
		end
	end

	// One cycle of read latency
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else
			oSUsiRd <= rdNext;
	end

endmodule

`default_nettype wire

// ==== synthesizer/synthesizerTop.sv ====
//--------------------------------------------------
// Synthesizer top level
// CSR and sample RAM on the bus, DMA into FIFO,
// FIFO drained by the I2S transmitter
//--------------------------------------------------
`default_nettype none

module synthesizerTop
	import synthPkg::*;
#(
	parameter int                     pDmaAdrsWidth = 8,
	parameter int                     pSampleWidth  = 16,
	parameter int                     pFifoDepthLog = 2,
	parameter int                     pBclkDiv      = 2,
	parameter logic [cBlockWidth-1:0] pCsrBlock     = 8'h04,
	parameter logic [cBlockWidth-1:0] pRamBlock     = 8'h05
)(
	input  logic                 iSCLK,
	input  logic                 iSRST,
	input  logic [cBusWidth-1:0] iSUsiWd,
	input  logic [cBusWidth-1:0] iSUsiAdrs,
	output logic [cBusWidth-1:0] oSUsiRd,
	output logic                 oI2sBclk,
	output logic                 oI2sLrclk,
	output logic                 oI2sData
);

	//--------------------------------------------------
	// Internal links
	//--------------------------------------------------
	logic                     i2sRst;
	logic [pDmaAdrsWidth-1:0] ramRdAdrs;
	logic [pSampleWidth-1:0]  ramRdData;
	logic                     fifoWrite;
	logic [pSampleWidth-1:0]  fifoWrData;
	logic                     fifoFull;
	logic                     fifoPop;
	logic [pSampleWidth-1:0]  fifoRdData;
	logic                     fifoEmpty;

	// Window, enable and done
	dmaCtrlIf #(.pDmaAdrsWidth(pDmaAdrsWidth)) dmaCtrl0 ();

	// Registers
	synthesizerCsr #(
		.pDmaAdrsWidth(pDmaAdrsWidth),
		.pCsrBlock    (pCsrBlock)
	) csr0 (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.iSUsiWd  (iSUsiWd),
		.iSUsiAdrs(iSUsiAdrs),
		.oSUsiRd  (oSUsiRd),
		.oI2sRst  (i2sRst),
		.dmaCtrl  (dmaCtrl0.csr)
	);

	// Sample storage
	sampleRam #(
		.pDmaAdrsWidth(pDmaAdrsWidth),
		.pSampleWidth (pSampleWidth),
		.pRamBlock    (pRamBlock)
	) ram0 (
		.iSCLK    (iSCLK),
		.iSUsiWd  (iSUsiWd),
		.iSUsiAdrs(iSUsiAdrs),
		.rdAdrs   (ramRdAdrs),
		.rdData   (ramRdData)
	);

	// Producer
	sampleDma #(
		.pDmaAdrsWidth(pDmaAdrsWidth),
		.pSampleWidth (pSampleWidth)
	) dma0 (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.dmaCtrl   (dmaCtrl0.dma),
		.ramRdAdrs (ramRdAdrs),
		.ramRdData (ramRdData),
		.fifoWrite (fifoWrite),
		.fifoWrData(fifoWrData),
		.fifoFull  (fifoFull)
	);

	// Buffer
	sampleFifo #(
		.pSampleWidth (pSampleWidth),
		.pFifoDepthLog(pFifoDepthLog)
	) fifo0 (
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.write (fifoWrite),
		.wrData(fifoWrData),
		.full  (fifoFull),
		.pop   (fifoPop),
		.rdData(fifoRdData),
		.empty (fifoEmpty)
	);

	// Consumer
	i2sTransmitter #(
		.pSampleWidth(pSampleWidth),
		.pBclkDiv    (pBclkDiv)
	) i2s0 (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.i2sRst    (i2sRst),
		.fifoPop   (fifoPop),
		.fifoRdData(fifoRdData),
		.fifoEmpty (fifoEmpty),
		.bclk      (oI2sBclk),
		.lrclk     (oI2sLrclk),
		.sdata     (oI2sData)
	);

endmodule

`default_nettype wire

// ==== verification/synthStim.txt ====
# Columns: op then hex fields; W adrs data writes, R adrs data reads and compares
# S data expects the next decoded I2S word, I n idles n cycles (decimal)
# Register reset values
R 00040000 00000000
R 00040004 00000000
R 00040008 000000FF
R 0004000C 00000000
R 00040010 00000000
# Writes read back zero padded, unmapped offset reads zero
W 40040000 FFFFFFFF
W 40040004 FFFFFF37
W 40040008 ABCD12C4
W 4004000C FFFFFFFE
W 40040010 00000003
R 00040000 00000001
R 00040004 00000037
R 00040008 000000C4
R 0004000C 00000000
R 00040010 00000001
R 00040020 00000000
W 40040000 00000000
W 40040010 00000000
# Sample memory, words 0 to 11
W 40050000 00009C4A
W 40050004 00003B17
W 40050008 0000E2D5
W 4005000C 00004F80
W 40050010 00001A6C
W 40050014 0000D739
W 40050018 000065F2
W 4005001C 0000B0A3
W 40050020 00002E5D
W 40050024 00008716
W 40050028 000053C8
W 4005002C 0000F94B
# Single shot over words 2 to 5
W 40040004 00000002
W 40040008 00000005
W 4004000C 00000001
S E2D5
S 4F80
S 1A6C
S D739
S 0000
S 0000
R 0004000C 00000000
# Cycle mode over words 0 to 2, three passes
W 40040004 00000000
W 40040008 00000002
W 40040010 00000001
W 4004000C 00000001
S 9C4A
S 3B17
S E2D5
S 9C4A
S 3B17
S E2D5
S 9C4A
S 3B17
S E2D5
R 0004000C 00000001
W 40040010 00000000
W 4004000C 00000000
I 700
S 0000
S 0000
R 0004000C 00000000
# Back-pressure over words 0 to 11
W 40040008 0000000B
W 4004000C 00000001
S 9C4A
S 3B17
S E2D5
S 4F80
S 1A6C
S D739
S 65F2
S B0A3
S 2E5D
S 8716
S 53C8
S F94B
S 0000
# I2S held in reset while the FIFO fills, words 3 to 8
W 40040000 00000001
W 40040004 00000003
W 40040008 00000008
W 4004000C 00000001
R 00040000 00000001
I 300
W 40040000 00000000
S 4F80
S 1A6C
S D739
S 65F2
S B0A3
S 2E5D
S 0000

// ==== verification/synthesizerTb.sv ====
//--------------------------------------------------
// Synthesizer testbench
// Replays bus operations from the stim file and
// decodes the I2S stream into sample words
//--------------------------------------------------
`default_nettype none

module synthesizerTb
	import synthPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int                     cSampleWidth = 16;
	localparam int                     cBclkDiv     = 2;
	localparam logic [cBlockWidth-1:0] cCsrBlock    = 8'h04;
	localparam logic [cBlockWidth-1:0] cRamBlock    = 8'h05;
	// Sum of the idle counts in the stim file
	localparam int                     cStimIdle    = 1000;
	// One stereo frame in iSCLK cycles
	localparam int                     cFrameCycles = 2 * cSampleWidth * 2 * cBclkDiv;
	// Idle time plus 200 frames of margin
	localparam int                     cCycleLimit  = cStimIdle + 200 * cFrameCycles;

	logic                    iSCLK;
	logic                    iSRST;
	logic [cBusWidth-1:0]    iSUsiWd;
	logic [cBusWidth-1:0]    iSUsiAdrs;
	logic [cBusWidth-1:0]    oSUsiRd;
	logic                    oI2sBclk;
	logic                    oI2sLrclk;
	logic                    oI2sData;

	int                      errors     = 0;
	int                      checks     = 0;
	int                      cycleCnt   = 0;
	int                      heldCycles = 0;
	// I2S reset register as last written
	logic                    rstHeld    = 1'b0;
	// Next sample check resyncs on the stream
	logic                    hunting    = 1'b1;
	logic                    prevWs     = 1'b0;
	logic                    framed     = 1'b0;
	logic [cSampleWidth-1:0] shiftAcc   = '0;
	logic [cSampleWidth-1:0] words [$];
	int                      fd;
	int                      n;
	int                      count;
	logic [63:0]             op;
	logic [cBusWidth-1:0]    adrs;
	logic [cBusWidth-1:0]    data;
	logic [8*120-1:0]        restOfLine;

	synthesizerTop #(
		.pBclkDiv (cBclkDiv),
		.pCsrBlock(cCsrBlock),
		.pRamBlock(cRamBlock)
	) dut0 (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.iSUsiWd  (iSUsiWd),
		.iSUsiAdrs(iSUsiAdrs),
		.oSUsiRd  (oSUsiRd),
		.oI2sBclk (oI2sBclk),
		.oI2sLrclk(oI2sLrclk),
		.oI2sData (oI2sData)
	);

	//--------------------------------------------------
	// Clock, cycle count, watchdog
	//--------------------------------------------------
	initial
		iSCLK = 1'b0;

	always #50 iSCLK = ~iSCLK;

	always @(posedge iSCLK)
		cycleCnt <= cycleCnt + 1;

	initial
	begin
		wait (cycleCnt >= cCycleLimit);
		$display("Timeout after %0d cycles, stimulus did not complete", cycleCnt);
		$display("Run done: %0d checks, %0d errors", checks, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

	//--------------------------------------------------
	// Checks and bus tasks
	//--------------------------------------------------
	task automatic checkValue(input string name, input logic [cBusWidth-1:0] exp,
		input logic [cBusWidth-1:0] got);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// Single-cycle write strobe
	task automatic busWrite(input logic [cBusWidth-1:0] wAdrs, input logic [cBusWidth-1:0] wData);
		iSUsiAdrs = wAdrs;
		iSUsiWd   = wData;
		// Track the I2S reset register for the hold monitor
		if (wAdrs[cWriteBit] && (wAdrs[cOffsetWidth +: cBlockWidth] == cCsrBlock) &&
			(wAdrs[cOffsetWidth-1:0] == offI2sRst))
			rstHeld = wData[0];
		@(posedge iSCLK);
		#10;
		iSUsiAdrs = '0;
		iSUsiWd   = '0;
	endtask

	// Data shows one cycle after the address
	task automatic busRead(input logic [cBusWidth-1:0] rAdrs, input logic [cBusWidth-1:0] exp);
		iSUsiAdrs = rAdrs;
		@(posedge iSCLK);
		#10;
		checkValue("oSUsiRd", exp, oSUsiRd);
		iSUsiAdrs = '0;
	endtask

	task automatic idleCycles(input int cycles);
		repeat (cycles)
		begin
			@(posedge iSCLK);
			#10;
		end
	endtask

	task automatic nextWord(output logic [cSampleWidth-1:0] word);
		while (words.size() == 0)
		begin
			@(posedge iSCLK);
			#10;
		end
		word = words.pop_front();
	endtask

	// After other ops, drop stale words and skip silence up to a sample
	task automatic expectSample(input logic [cSampleWidth-1:0] exp);
		logic [cSampleWidth-1:0] got;
		if (hunting)
			words.delete();
		nextWord(got);
		while (hunting && (exp != 0) && (got == 0))
			nextWord(got);
		hunting = 1'b0;
		checkValue("oI2sData word", exp, got);
	endtask

	//--------------------------------------------------
	// I2S decoder
	//--------------------------------------------------
	// Word select edge carries the LSB of the word before
	always @(posedge oI2sBclk)
	begin
		if (oI2sLrclk != prevWs)
		begin
			if (framed)
				words.push_back({shiftAcc[cSampleWidth-2:0], oI2sData});
			framed   = 1'b1;
			shiftAcc = '0;
		end
		else
			shiftAcc = {shiftAcc[cSampleWidth-2:0], oI2sData};
		prevWs = oI2sLrclk;
	end

	// Outputs low two cycles into an I2S reset
	always @(posedge iSCLK)
	begin
		#5;
		if (rstHeld)
			heldCycles = heldCycles + 1;
		else
			heldCycles = 0;
		if (heldCycles >= 2)
		begin
			checkValue("oI2sBclk", 0, oI2sBclk);
			checkValue("oI2sLrclk", 0, oI2sLrclk);
			checkValue("oI2sData", 0, oI2sData);
		end
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	initial
	begin
		iSRST     = 1'b1;
		iSUsiWd   = '0;
		iSUsiAdrs = '0;
		repeat (5) @(posedge iSCLK);
		#10;
		iSRST = 1'b0;
		fd = $fopen("verification/synthStim.txt", "r");
		if (fd == 0)
		begin
			$display("Stimulus file could not be opened");
			errors++;
		end
		else
		begin
			while ($fscanf(fd, "%s", op) == 1)
			begin
				case (op)
					"#":
						n = $fgets(restOfLine, fd);
					"W":
					begin
						n = $fscanf(fd, "%h %h", adrs, data);
						busWrite(adrs, data);
						hunting = 1'b1;
					end
					"R":
					begin
						n = $fscanf(fd, "%h %h", adrs, data);
						busRead(adrs, data);
						hunting = 1'b1;
					end
					"S":
					begin
						n = $fscanf(fd, "%h", data);
						expectSample(data[cSampleWidth-1:0]);
					end
					"I":
					begin
						n = $fscanf(fd, "%d", count);
						idleCycles(count);
						hunting = 1'b1;
					end
					default:
					begin
						$display("Unknown operation in stimulus file: %0s", op);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		$display("Run done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
